/* hw/usb_ctl_settings.svh */
`ifndef USB_CTL_SETTINGS_SVH
`define USB_CTL_SETTINGS_SVH

// Device identity placed in the device descriptor
`define USB_VENDOR_ID 16'hFACE
`define USB_PRODUCT_ID 16'h0BDE

// Endpoint 0 packet size, also the burst chop limit
`define USB_MAX_PACKET 64

`define DESC_ROM_ABITS 6

// Byte offsets of each table inside the descriptor ROM
`define DESC_DEVICE_START 0
`define DESC_CONFIG_START 18
`define DESC_LANG_START 36
`define DESC_PRODUCT_START 40
// Three status words follow: device, interface, endpoint
`define DESC_STATUS_START 50

`endif

/* hw/usb_ctl_pkg.sv */
package usb_ctl_pkg;

  // Standard bRequest codes
  localparam logic [7:0] req_get_status = 8'h00;
  localparam logic [7:0] req_set_address = 8'h05;
  localparam logic [7:0] req_get_descriptor = 8'h06;
  localparam logic [7:0] req_set_configuration = 8'h09;
  localparam logic [7:0] req_set_interface = 8'h0B;

  typedef enum logic [2:0] {
    get_status,
    set_address,
    get_descriptor,
    set_configuration,
    set_interface,
    unsupported,
    ignored
  } req_kind_e;

  // wValue as seen by GET_DESCRIPTOR
  typedef struct packed {
    logic [7:0] desc_type;
    logic [7:0] desc_index;
  } desc_sel_t;

  // Same 16 bits, also read as a plain number by the SET requests
  typedef union packed {
    desc_sel_t desc;
    logic [15:0] number;
  } setup_value_u;

endpackage

/* hw/setup_req_if.sv */
interface setup_req_if;

  logic select;
  logic start;
  logic [3:0] endpt;
  logic [7:0] req_type;
  logic [7:0] request;
  usb_ctl_pkg::setup_value_u value;
  logic [15:0] length;

  modport top(
    output select, start, endpt, req_type, request, value, length
  );

  modport pipe(
    input select, start, endpt, req_type, request, value, length
  );

endinterface

/* hw/desc_stream_if.sv */
interface desc_stream_if;

  logic valid;
  logic ready;
  logic last;
  logic [7:0] data;

  modport source(
    output valid, last, data,
    input ready
  );

  modport sink(
    input valid, last, data,
    output ready
  );

endinterface

/* hw/desc_rom.sv */
`include "usb_ctl_settings.svh"

module desc_rom (
  input  logic [`DESC_ROM_ABITS-1:0] addr_i,
  output logic [7:0] data_o,
  output logic last_o
);

  localparam int rom_bytes = 1 << `DESC_ROM_ABITS;
  localparam logic [15:0] vendor_id = `USB_VENDOR_ID;
  localparam logic [15:0] product_id = `USB_PRODUCT_ID;

  // First byte on the wire sits in the top byte of each vector
  localparam logic [8*18-1:0] device_desc = {
    8'h12, 8'h01, 8'h00, 8'h02, 8'hFF, 8'h00, 8'h00, 8'(`USB_MAX_PACKET),
    vendor_id[7:0], vendor_id[15:8], product_id[7:0], product_id[15:8],
    8'h00, 8'h00, 8'h00, 8'h02, 8'h00, 8'h01
  };

  // Configuration followed by its single interface, no endpoints
  localparam logic [8*18-1:0] config_desc = {
    8'h09, 8'h02, 8'h12, 8'h00, 8'h01, 8'h01, 8'h00, 8'hC0, 8'h32,
    8'h09, 8'h04, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00
  };

  localparam logic [8*4-1:0] lang_desc = {8'h04, 8'h03, 8'h09, 8'h04};

  // "USB0" in UTF-16LE
  localparam logic [8*10-1:0] product_desc = {
    8'h0A, 8'h03, 8'h55, 8'h00, 8'h53, 8'h00, 8'h42, 8'h00, 8'h30, 8'h00
  };

  // Self-powered device, then interface and endpoint
  localparam logic [8*6-1:0] status_words = {8'h01, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};

  // Returns {last, byte} for byte idx of a descriptor of len bytes
  function automatic logic [8:0] desc_byte(logic [8*18-1:0] desc, int len, int idx);
    return {idx == len - 1, desc[8*(len-1-idx) +: 8]};
  endfunction

  function automatic logic [rom_bytes*9-1:0] build_rom();
    logic [rom_bytes*9-1:0] t;
    t = '0;
    for (int i = 0; i < 18; i++) begin
      t[9*(`DESC_DEVICE_START+i) +: 9] = desc_byte(device_desc, 18, i);
      t[9*(`DESC_CONFIG_START+i) +: 9] = desc_byte(config_desc, 18, i);
    end
    for (int i = 0; i < 4; i++) begin
      t[9*(`DESC_LANG_START+i) +: 9] = desc_byte(lang_desc, 4, i);
    end
    for (int i = 0; i < 10; i++) begin
      t[9*(`DESC_PRODUCT_START+i) +: 9] = desc_byte(product_desc, 10, i);
    end
    // Every status word is its own two-byte reply
    for (int i = 0; i < 6; i++) begin
      t[9*(`DESC_STATUS_START+i) +: 9] = {i % 2 == 1, status_words[8*(5-i) +: 8]};
    end
    return t;
  endfunction

  localparam logic [rom_bytes*9-1:0] rom = build_rom();

  assign {last_o, data_o} = rom[9*addr_i +: 9];

endmodule

/* hw/req_decode.sv */
`include "usb_ctl_settings.svh"

module req_decode (
  input  logic clock,
  setup_req_if.pipe req,
  output usb_ctl_pkg::req_kind_e kind_o,
  output logic [`DESC_ROM_ABITS-1:0] rom_start_o,
  output logic decoded_o
);

  typedef logic [`DESC_ROM_ABITS-1:0] rom_addr_t;

  logic start_q;
  logic std_q;
  usb_ctl_pkg::desc_sel_t sel;
  usb_ctl_pkg::req_kind_e kind_d;
  rom_addr_t start_d;

  assign sel = req.value.desc;

  // First stage, standard request aimed at endpoint 0
  always_ff @(posedge clock) begin
    start_q <= req.select && req.start;
    std_q <= req.req_type[6:5] == 2'b00 && req.endpt == 4'h0;
  end

  always_comb begin
    kind_d = usb_ctl_pkg::ignored;
    start_d = '0;
    if (std_q) begin
      case (req.request)
        usb_ctl_pkg::req_get_status: begin
          kind_d = usb_ctl_pkg::get_status;
          case (req.req_type[1:0])
            2'd0: start_d = rom_addr_t'(`DESC_STATUS_START);
            2'd1: start_d = rom_addr_t'(`DESC_STATUS_START + 2);
            2'd2: start_d = rom_addr_t'(`DESC_STATUS_START + 4);
            default: kind_d = usb_ctl_pkg::unsupported;
          endcase
        end
        usb_ctl_pkg::req_get_descriptor: begin
          kind_d = usb_ctl_pkg::get_descriptor;
          case (sel.desc_type)
            8'h01: start_d = rom_addr_t'(`DESC_DEVICE_START);
            8'h02: start_d = rom_addr_t'(`DESC_CONFIG_START);
            8'h03: begin
              // Only the language table and the product string exist
              if (sel.desc_index == 8'd0) begin
                start_d = rom_addr_t'(`DESC_LANG_START);
              end else if (sel.desc_index == 8'd2) begin
                start_d = rom_addr_t'(`DESC_PRODUCT_START);
              end else begin
                kind_d = usb_ctl_pkg::unsupported;
              end
            end
            default: kind_d = usb_ctl_pkg::unsupported;
          endcase
        end
        usb_ctl_pkg::req_set_address: kind_d = usb_ctl_pkg::set_address;
        usb_ctl_pkg::req_set_configuration: kind_d = usb_ctl_pkg::set_configuration;
        usb_ctl_pkg::req_set_interface: kind_d = usb_ctl_pkg::set_interface;
        default: kind_d = usb_ctl_pkg::unsupported;
      endcase
    end
  end

  // Second stage, a deselect in between drops the request
  always_ff @(posedge clock) begin
    decoded_o <= start_q && req.select;
    if (start_q) begin
      kind_o <= kind_d;
      rom_start_o <= start_d;
    end
  end

endmodule

/* hw/axis_chop.sv */
module axis_chop (
  input  logic clock,
  input  logic reset,
  input  logic active_i,
  input  logic [6:0] length_i,
  output logic final_o,
  desc_stream_if.sink s,
  output logic m_tvalid_o,
  input  logic m_tready_i,
  output logic m_tlast_o,
  output logic [7:0] m_tdata_o
);

  logic [6:0] count_q;
  logic [6:0] count_next;
  logic take;

  assign count_next = count_q + 7'd1;

  // Accept while the output slot frees up and the limit is not yet hit
  assign s.ready = active_i && count_q < length_i && (!m_tvalid_o || m_tready_i);
  assign take = s.valid && s.ready;
  assign final_o = take && count_next == length_i;

  always_ff @(posedge clock) begin
    if (reset || !active_i) begin
      m_tvalid_o <= 1'b0;
      count_q <= 7'd0;
    end else if (take) begin
      m_tvalid_o <= 1'b1;
      count_q <= count_next;
    end else if (m_tready_i) begin
      m_tvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      m_tdata_o <= s.data;
      // Either the descriptor ends or the burst limit cuts it
      m_tlast_o <= s.last || final_o;
    end
  end

endmodule

/* hw/ctl_pipe0.sv */
`include "usb_ctl_settings.svh"

module ctl_pipe0 (
  input  logic clock,
  input  logic reset,
  setup_req_if.pipe req,
  output logic error_o,
  output logic configured_o,
  output logic usb_enum_o,
  output logic [6:0] usb_addr_o,
  output logic [2:0] usb_conf_o,
  output logic m_tvalid_o,
  input  logic m_tready_i,
  output logic m_tlast_o,
  output logic [7:0] m_tdata_o
);

  usb_ctl_pkg::req_kind_e kind;
  logic decoded;
  logic [`DESC_ROM_ABITS-1:0] rom_start;
  logic [`DESC_ROM_ABITS-1:0] rom_addr_q;
  logic [7:0] rom_data;
  logic rom_last;
  logic fetch_q;
  logic act_q;
  logic [6:0] len_q;
  logic chop_final;
  logic wants_data;
  logic stream_end;

  desc_stream_if stream ();

  req_decode req_decode_i (
    .clock(clock),
    .req(req),
    .kind_o(kind),
    .rom_start_o(rom_start),
    .decoded_o(decoded)
  );

  desc_rom desc_rom_i (
    .addr_i(rom_addr_q),
    .data_o(rom_data),
    .last_o(rom_last)
  );

  // Reads with a zero wLength have no data stage
  assign wants_data = decoded && req.length != 16'd0 &&
                      (kind == usb_ctl_pkg::get_status || kind == usb_ctl_pkg::get_descriptor);
  assign stream_end = m_tvalid_o && m_tready_i && m_tlast_o;

  assign stream.valid = fetch_q;
  assign stream.data = rom_data;
  assign stream.last = rom_last;

  always_ff @(posedge clock) begin
    if (reset) begin
      error_o <= 1'b0;
      usb_enum_o <= 1'b0;
      usb_addr_o <= 7'd0;
      usb_conf_o <= 3'd0;
      configured_o <= 1'b0;
    end else begin
      if (decoded && kind == usb_ctl_pkg::set_address) begin
        usb_enum_o <= 1'b1;
        usb_addr_o <= req.value.number[6:0];
      end
      if (decoded && kind == usb_ctl_pkg::set_configuration) begin
        usb_conf_o <= req.value.number[2:0];
        configured_o <= req.value.number != 16'd0;
      end
      if (!req.select) begin
        error_o <= 1'b0;
      end else if (decoded && kind != usb_ctl_pkg::ignored) begin
        error_o <= kind == usb_ctl_pkg::unsupported;
      end
    end
  end

  // Fetch runs until the ROM or the chopper ends it, act_q until the last byte leaves
  always_ff @(posedge clock) begin
    if (reset || !req.select) begin
      fetch_q <= 1'b0;
      act_q <= 1'b0;
    end else if (wants_data) begin
      fetch_q <= 1'b1;
      act_q <= 1'b1;
    end else begin
      if (stream.valid && stream.ready && (rom_last || chop_final)) begin
        fetch_q <= 1'b0;
      end
      if (stream_end) begin
        act_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wants_data) begin
      rom_addr_q <= rom_start;
    end else if (stream.valid && stream.ready) begin
      rom_addr_q <= rom_addr_q + 1'b1;
    end
    if (decoded) begin
      len_q <= req.length >= 16'(`USB_MAX_PACKET) ? 7'(`USB_MAX_PACKET) : req.length[6:0];
    end
  end

  axis_chop axis_chop_i (
    .clock(clock),
    .reset(reset),
    .active_i(act_q && req.select),
    .length_i(len_q),
    .final_o(chop_final),
    .s(stream),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o(m_tlast_o),
    .m_tdata_o(m_tdata_o)
  );

endmodule

/* hw/usb_ctl_top.sv */
module usb_ctl_top (
  input  logic clock,
  input  logic reset,
  input  logic select_i,
  input  logic start_i,
  input  logic [3:0] req_endpt_i,
  input  logic [7:0] req_type_i,
  input  logic [7:0] req_args_i,
  input  logic [15:0] req_value_i,
  input  logic [15:0] req_length_i,
  output logic error_o,
  output logic configured_o,
  output logic usb_enum_o,
  output logic [6:0] usb_addr_o,
  output logic [2:0] usb_conf_o,
  output logic m_tvalid_o,
  input  logic m_tready_i,
  output logic m_tlast_o,
  output logic [7:0] m_tdata_o
);

  setup_req_if req ();

  // SETUP fields straight from the pins
  assign req.select = select_i;
  assign req.start = start_i;
  assign req.endpt = req_endpt_i;
  assign req.req_type = req_type_i;
  assign req.request = req_args_i;
  assign req.value = req_value_i;
  assign req.length = req_length_i;

  ctl_pipe0 ctl_pipe0_i (
    .clock(clock),
    .reset(reset),
    .req(req),
    .error_o(error_o),
    .configured_o(configured_o),
    .usb_enum_o(usb_enum_o),
    .usb_addr_o(usb_addr_o),
    .usb_conf_o(usb_conf_o),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o(m_tlast_o),
    .m_tdata_o(m_tdata_o)
  );

endmodule

/* verification/usb_ctl_tb.sv */
`include "usb_ctl_settings.svh"

module usb_ctl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_reqs = 200;
  localparam logic [15:0] vid = `USB_VENDOR_ID;
  localparam logic [15:0] pid = `USB_PRODUCT_ID;

  logic clock;
  logic reset;
  logic select_i;
  logic start_i;
  logic [3:0] req_endpt_i;
  logic [7:0] req_type_i;
  logic [7:0] req_args_i;
  logic [15:0] req_value_i;
  logic [15:0] req_length_i;
  logic m_tready_i;
  logic error_o;
  logic configured_o;
  logic usb_enum_o;
  logic [6:0] usb_addr_o;
  logic [2:0] usb_conf_o;
  logic m_tvalid_o;
  logic m_tlast_o;
  logic [7:0] m_tdata_o;

  // Expected ROM image and shadow device state
  logic [7:0] tbl [64];
  logic [31:0] rng = 32'd5511;
  int errors = 0;
  logic [6:0] sh_addr = '0;
  logic sh_enum = 1'b0;
  logic [2:0] sh_conf = '0;
  logic sh_cfgd = 1'b0;
  logic sh_err = 1'b0;
  logic [6:0] nx_addr;
  logic nx_enum;
  logic [2:0] nx_conf;
  logic nx_cfgd;
  logic nx_err;

  always #20 clock = ~clock;

  usb_ctl_top usb_ctl_top_i (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Step to the next drive point and draw fresh back-pressure
  task automatic tick();
    @(posedge clock);
    #2;
    rng = xorshift32(rng);
    m_tready_i = rng[7];
  endtask

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_state(input logic [6:0] a, input logic e, input logic [2:0] c,
                             input logic cf, input logic er);
    check_val("usb_addr_o", usb_addr_o, a);
    check_val("usb_enum_o", usb_enum_o, e);
    check_val("usb_conf_o", usb_conf_o, c);
    check_val("configured_o", configured_o, cf);
    check_val("error_o", error_o, er);
  endtask

  // Bytes are listed in wire order with the first byte on top
  task automatic load_desc(input int base, input int n, input logic [8*18-1:0] v);
    for (int i = 0; i < n; i++) begin
      tbl[base + i] = v[8*(n-1-i) +: 8];
    end
  endtask

  task automatic run_request(input logic [3:0] ep, input logic [7:0] rtype,
                             input logic [7:0] breq, input logic [15:0] value,
                             input logic [15:0] wlen, input int rd_start, input int rd_len);
    int c;
    int n;
    logic done;
    logic held;
    logic [7:0] held_data;
    logic held_last;
    tick();
    select_i = 1'b1;
    start_i = 1'b1;
    req_endpt_i = ep;
    req_type_i = rtype;
    req_args_i = breq;
    req_value_i = value;
    req_length_i = wlen;
    c = 0;
    n = 0;
    done = 1'b0;
    held = 1'b0;
    while (!done) begin
      tick();
      start_i = 1'b0;
      c++;
      @(negedge clock);
      // State moves exactly two edges after the start edge
      if (c == 2) check_state(sh_addr, sh_enum, sh_conf, sh_cfgd, sh_err);
      if (c == 3) begin
        check_state(nx_addr, nx_enum, nx_conf, nx_cfgd, nx_err);
        {sh_addr, sh_enum, sh_conf, sh_cfgd, sh_err} = {nx_addr, nx_enum, nx_conf, nx_cfgd, nx_err};
      end
      if (c <= 2 && m_tvalid_o) begin
        errors++;
        $display("Stream started before the request was decoded at %0t", $time);
      end
      // A stalled byte must stay on the bus unchanged
      if (held && (m_tvalid_o !== 1'b1 || m_tdata_o !== held_data ||
                   m_tlast_o !== held_last)) begin
        errors++;
        $display("Stream byte dropped or changed while stalled at %0t", $time);
      end
      held = m_tvalid_o && !m_tready_i;
      held_data = m_tdata_o;
      held_last = m_tlast_o;
      if (m_tvalid_o && m_tready_i) begin
        if (n >= rd_len) begin
          errors++;
          $display("Unexpected stream byte 0x%0h at %0t", m_tdata_o, $time);
        end else begin
          check_val("m_tdata_o", m_tdata_o, tbl[rd_start + n]);
          check_val("m_tlast_o", m_tlast_o, n == rd_len - 1);
        end
        n++;
        if (m_tlast_o) done = 1'b1;
      end
      if (rd_len == 0 && c >= 8) done = 1'b1;
      if (c > 250) begin
        errors++;
        $display("Stream did not finish within 250 cycles at %0t", $time);
        done = 1'b1;
      end
    end
    check_val("m_tdata_o byte count", n, rd_len);
    tick();
    select_i = 1'b0;
    tick();
    @(negedge clock);
    check_val("error_o", error_o, 1'b0);
    check_val("m_tvalid_o", m_tvalid_o, 1'b0);
    sh_err = 1'b0;
  endtask

  initial begin
    #(num_reqs * 300 * 40);
    $display("Watchdog expired, the run hung");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    logic [2:0] pick;
    logic [2:0] sub;
    logic flag;
    logic [3:0] ep;
    logic [7:0] rtype;
    logic [7:0] breq;
    logic [15:0] val;
    logic [15:0] wlen;
    int rd_start;
    int rd_len;
    int dlen;
    clock = 1'b0;
    reset = 1'b1;
    select_i = 1'b0;
    start_i = 1'b0;
    req_endpt_i = '0;
    req_type_i = '0;
    req_args_i = '0;
    req_value_i = '0;
    req_length_i = '0;
    m_tready_i = 1'b0;
    for (int i = 0; i < 64; i++) tbl[i] = 8'h00;
    load_desc(`DESC_DEVICE_START, 18, {8'h12, 8'h01, 8'h00, 8'h02, 8'hFF, 8'h00, 8'h00,
      8'(`USB_MAX_PACKET), vid[7:0], vid[15:8], pid[7:0], pid[15:8],
      8'h00, 8'h00, 8'h00, 8'h02, 8'h00, 8'h01});
    load_desc(`DESC_CONFIG_START, 18, {8'h09, 8'h02, 8'h12, 8'h00, 8'h01, 8'h01, 8'h00,
      8'hC0, 8'h32, 8'h09, 8'h04, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00});
    load_desc(`DESC_LANG_START, 4, {8'h04, 8'h03, 8'h09, 8'h04});
    load_desc(`DESC_PRODUCT_START, 10, {8'h0A, 8'h03, "U", 8'h00, "S", 8'h00, "B", 8'h00,
      "0", 8'h00});
    load_desc(`DESC_STATUS_START, 6, {8'h01, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00});
    repeat (16) tick();
    reset = 1'b0;
    // Quiet after reset until the first request
    repeat (4) begin
      tick();
      @(negedge clock);
      check_state(7'd0, 1'b0, 3'd0, 1'b0, 1'b0);
      check_val("m_tvalid_o", m_tvalid_o, 1'b0);
    end
    for (int r = 0; r < num_reqs; r++) begin
      rng = xorshift32(rng);
      pick = rng[2:0];
      sub = rng[10:8];
      flag = rng[11];
      rng = xorshift32(rng);
      val = rng[15:0];
      rng = xorshift32(rng);
      wlen = rng[1:0] == 2'd0 ? 16'd0 : (rng[2] ? {9'd0, rng[9:3]} : rng[31:16]);
      ep = 4'h0;
      rtype = 8'h00;
      breq = 8'h00;
      rd_start = 0;
      dlen = 0;
      {nx_addr, nx_enum, nx_conf, nx_cfgd, nx_err} = {sh_addr, sh_enum, sh_conf, sh_cfgd, 1'b0};
      case (pick)
        3'd0: begin
          breq = 8'h05;
          nx_addr = val[6:0];
          nx_enum = 1'b1;
        end
        3'd1: begin
          breq = 8'h09;
          val = flag ? val : {13'd0, val[2:0]};
          nx_conf = val[2:0];
          nx_cfgd = val != 16'd0;
        end
        3'd2, 3'd3: begin
          breq = 8'h06;
          case (sub[1:0])
            2'd0: {val[15:8], rd_start, dlen} = {8'h01, 32'(`DESC_DEVICE_START), 32'd18};
            2'd1: {val[15:8], rd_start, dlen} = {8'h02, 32'(`DESC_CONFIG_START), 32'd18};
            2'd2: {val, rd_start, dlen} = {16'h0300, 32'(`DESC_LANG_START), 32'd4};
            default: {val, rd_start, dlen} = {16'h0302, 32'(`DESC_PRODUCT_START), 32'd10};
          endcase
        end
        3'd4: begin
          rtype = 8'h80 | (sub % 3);
          rd_start = `DESC_STATUS_START + 2 * (sub % 3);
          dlen = 2;
        end
        3'd5: begin
          nx_err = 1'b1;
          case (sub[1:0])
            2'd0: breq = {4'h1, val[3:0]};
            2'd1: {breq, val[15:8]} = {8'h06, val[15:8] | 8'h04};
            2'd2: {breq, val} = {8'h06, 8'h03, val[7:0] | 8'h01};
            default: rtype = 8'h83;
          endcase
        end
        3'd6: begin
          // Class request or another endpoint leaves the state alone
          breq = sub[0] ? 8'h05 : 8'h09;
          if (flag) rtype = 8'h21;
          else ep = 4'h1 | val[3:0];
        end
        default: breq = 8'h0B;
      endcase
      rd_len = dlen;
      if (wlen < rd_len) rd_len = wlen;
      if (rd_len > `USB_MAX_PACKET) rd_len = `USB_MAX_PACKET;
      run_request(ep, rtype, breq, val, wlen, rd_start, rd_len);
    end
    $display("Finished %0d requests with %0d errors", num_reqs, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+hw
hw/usb_ctl_pkg.sv
hw/setup_req_if.sv
hw/desc_stream_if.sv
hw/desc_rom.sv
hw/req_decode.sv
hw/axis_chop.sv
hw/ctl_pipe0.sv
hw/usb_ctl_top.sv
verification/usb_ctl_tb.sv
